/* verilog/spdif_frame_pkg.sv */
package spdif_frame_pkg;

	// Preamble type of a subframe
	typedef enum logic [1:0] {
		PRE_Z = 2'd0,  // Left channel, first frame of a block
		PRE_X = 2'd1,  // Other left words
		PRE_Y = 2'd2   // Right channel
	} preamble_e;

	// Toggle patterns of the eight preamble cells, MSB goes out first
	localparam logic [7:0] PREAMBLE_Z = 8'b1001_1100;
	localparam logic [7:0] PREAMBLE_X = 8'b1001_0011;
	localparam logic [7:0] PREAMBLE_Y = 8'b1001_0110;

	localparam int BLOCK_FRAMES       = 192;
	localparam int CELLS_PER_SUBFRAME = 64;  // 32 slots of two cells

	// Sample frequency in channel status bits 24 to 27, bit 24 is the LSB
	localparam logic [3:0] RATE_CODE_48K  = 4'b0010;
	localparam logic [3:0] RATE_CODE_44K1 = 4'b0000;
	localparam logic [3:0] RATE_CODE_32K  = 4'b0011;

	// One subframe word, bit n of raw is slot n on the line
	typedef union packed {
		struct packed {
			logic        p;      // Even parity over slots 4 to 31
			logic        c;
			logic        u;
			logic        v;
			logic [15:0] audio;  // Slot 12 carries the LSB
			logic [7:0]  aux;    // Aux nibble and unused LSBs of a 24-bit word
			logic [1:0]  pad;
			preamble_e   pre;
		} fields;
		logic [31:0] raw;
	} subframe_u;

endpackage

/* verilog/spdif_timing_pkg.sv */
package spdif_timing_pkg;

	// Fixed point denominator of the divider error term
	localparam longint unsigned ERROR_BASE = 10000;

	localparam longint unsigned CELLS_PER_SAMPLE = 128;  // Two subframes per sample period

	// Builder needs a spare clock between two cells
	localparam int MIN_WHOLE_CYCLES = 3;

	function automatic longint unsigned whole_cycles(longint unsigned clk_rate,
			longint unsigned audio_rate);
		return clk_rate / (audio_rate * CELLS_PER_SAMPLE);
	endfunction

	// Fractional part of a cell period in units of ERROR_BASE
	function automatic longint unsigned errors_per_cell(longint unsigned clk_rate,
			longint unsigned audio_rate);
		return (clk_rate * ERROR_BASE) / (audio_rate * CELLS_PER_SAMPLE)
			- whole_cycles(clk_rate, audio_rate) * ERROR_BASE;
	endfunction

endpackage

/* verilog/spdif_bit_timer.sv */
module spdif_bit_timer #(
	parameter int unsigned CLK_RATE   = 50000000,
	parameter int unsigned AUDIO_RATE = 48000
) (
	input  logic clk_i,
	input  logic reset,
	input  logic half_rate,
	output logic cell_ce
);

	localparam int WHOLE_CYCLES = int'(spdif_timing_pkg::whole_cycles(CLK_RATE, AUDIO_RATE));
	localparam int CNT_W        = $clog2(WHOLE_CYCLES + 1);
	localparam int ERR_W        = $clog2(2 * spdif_timing_pkg::ERROR_BASE);

	localparam logic [ERR_W-1:0] BASE = ERR_W'(spdif_timing_pkg::ERROR_BASE);
	localparam logic [ERR_W-1:0] EPC  =
		ERR_W'(spdif_timing_pkg::errors_per_cell(CLK_RATE, AUDIO_RATE));

	localparam logic [CNT_W-1:0] LAST_SHORT = CNT_W'(WHOLE_CYCLES - 1);
	localparam logic [CNT_W-1:0] LAST_LONG  = CNT_W'(WHOLE_CYCLES);

	logic [CNT_W-1:0] count_q;
	logic [ERR_W-1:0] error_q;
	logic             slot_q;  // Alternates every cell slot

	// Period counter, error accumulator picks the long period
	always_ff @(posedge clk_i) begin
		if (reset) begin
			count_q <= '0;
			error_q <= '0;
		end else if (count_q == LAST_SHORT) begin
			if (error_q < BASE - EPC) begin
				error_q <= error_q + EPC;
				count_q <= '0;
			end else begin
				error_q <= error_q + EPC - BASE;  // Carry out, stretch by a clock
				count_q <= LAST_LONG;
			end
		end else if (count_q == LAST_LONG) begin
			count_q <= '0;
		end else begin
			count_q <= count_q + 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset) begin
			slot_q  <= 1'b0;
			cell_ce <= 1'b0;
		end else begin
			cell_ce <= 1'b0;
			if (count_q == '0) begin
				slot_q  <= ~slot_q;
				cell_ce <= ~half_rate | slot_q;  // Half rate drops every second slot
			end
		end
	end

	assert property (@(posedge clk_i) disable iff (reset)
		WHOLE_CYCLES >= spdif_timing_pkg::MIN_WHOLE_CYCLES)
		else $error("cell period of %0d clocks leaves no room for the builder", WHOLE_CYCLES);

	assert property (@(posedge clk_i) disable iff (reset) cell_ce |=> !cell_ce)
		else $error("back to back cell enables");

endmodule

/* verilog/spdif_subframe_builder.sv */
module spdif_subframe_builder #(
	parameter int unsigned AUDIO_RATE = 48000
) (
	input  logic                       clk_i,
	input  logic                       reset,
	input  logic [15:0]                audio_l,
	input  logic [15:0]                audio_r,
	input  logic                       word_taken,
	output spdif_frame_pkg::subframe_u subframe,
	output logic                       sample_req
);

	localparam int FRAME_W = $clog2(spdif_frame_pkg::BLOCK_FRAMES);

	localparam logic [FRAME_W-1:0] LAST_FRAME = FRAME_W'(spdif_frame_pkg::BLOCK_FRAMES - 1);

	localparam logic [3:0] RATE_CODE =
		(AUDIO_RATE == 44100) ? spdif_frame_pkg::RATE_CODE_44K1 :
		(AUDIO_RATE == 32000) ? spdif_frame_pkg::RATE_CODE_32K  :
		                        spdif_frame_pkg::RATE_CODE_48K;

	// Consumer channel status, only the sample frequency is set
	localparam logic [spdif_frame_pkg::BLOCK_FRAMES-1:0] STATUS =
		{{(spdif_frame_pkg::BLOCK_FRAMES - 28){1'b0}}, RATE_CODE, 24'd0};

	logic               right_q;     // Channel of the word on subframe
	logic [FRAME_W-1:0] frame_q;
	logic               prime_q;     // Forces the first load after reset
	logic [15:0]        right_hold;

	logic                       load;
	logic                       next_right;
	logic [FRAME_W-1:0]         next_frame;
	spdif_frame_pkg::subframe_u next_word;

	assign load       = word_taken | prime_q;
	assign next_right = ~right_q;

	always_comb begin
		next_frame = frame_q;
		if (right_q) begin
			next_frame = (frame_q == LAST_FRAME) ? '0 : frame_q + 1'b1;
		end
	end

	always_comb begin
		next_word = '0;
		if (next_right) begin
			next_word.fields.pre   = spdif_frame_pkg::PRE_Y;
			next_word.fields.audio = right_hold;
		end else begin
			// Z opens each block of 192 frames
			next_word.fields.pre   = (next_frame == '0) ? spdif_frame_pkg::PRE_Z
			                                            : spdif_frame_pkg::PRE_X;
			next_word.fields.audio = audio_l;
		end
		next_word.fields.v = 1'b0;
		next_word.fields.u = 1'b0;
		next_word.fields.c = STATUS[next_frame];
		next_word.fields.p = ^next_word.raw[30:4];
	end

	always_ff @(posedge clk_i) begin
		if (reset) begin
			right_q    <= 1'b1;        // So the first word is left of frame 0
			frame_q    <= LAST_FRAME;
			prime_q    <= 1'b1;
			sample_req <= 1'b0;
		end else begin
			prime_q    <= 1'b0;
			sample_req <= load & ~next_right;
			if (load) begin
				right_q <= next_right;
				frame_q <= next_frame;
			end
		end
	end

	// The right sample is held with its left partner
	always_ff @(posedge clk_i) begin
		if (load) begin
			subframe <= next_word;
			if (!next_right) begin
				right_hold <= audio_r;
			end
		end
	end

	assert property (@(posedge clk_i) disable iff (reset)
		sample_req |-> subframe.fields.pre != spdif_frame_pkg::PRE_Y)
		else $error("sample request on a right word");

endmodule

/* verilog/spdif_biphase_serializer.sv */
module spdif_biphase_serializer (
	input  logic                       clk_i,
	input  logic                       reset,
	input  logic                       cell_ce,
	input  spdif_frame_pkg::subframe_u subframe,
	output logic                       word_taken,
	output logic                       spdif_o
);

	localparam int CNT_W = $clog2(spdif_frame_pkg::CELLS_PER_SUBFRAME);

	logic [CNT_W-1:0]           cell_q;
	spdif_frame_pkg::subframe_u word_q;
	spdif_frame_pkg::preamble_e pre;
	logic [7:0]                 pattern;
	logic                       toggle;

	assign word_taken = cell_ce && (cell_q == '0);

	// Cell 0 goes out on the clock the word is latched
	assign pre = (cell_q == '0) ? subframe.fields.pre : word_q.fields.pre;

	always_comb begin
		case (pre)
			spdif_frame_pkg::PRE_Z: pattern = spdif_frame_pkg::PREAMBLE_Z;
			spdif_frame_pkg::PRE_Y: pattern = spdif_frame_pkg::PREAMBLE_Y;
			default:                pattern = spdif_frame_pkg::PREAMBLE_X;
		endcase
	end

	// Biphase mark, every slot starts with a toggle
	always_comb begin
		if (cell_q < CNT_W'(8)) begin
			toggle = pattern[3'd7 - cell_q[2:0]];
		end else if (!cell_q[0]) begin
			toggle = 1'b1;
		end else begin
			toggle = word_q.raw[cell_q[CNT_W-1:1]];  // Mid slot toggle for a 1
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset) begin
			cell_q  <= '0;
			spdif_o <= 1'b0;
		end else if (cell_ce) begin
			cell_q  <= cell_q + 1'b1;  // Wraps after the last cell
			spdif_o <= spdif_o ^ toggle;
		end
	end

	always_ff @(posedge clk_i) begin
		if (word_taken) begin
			word_q <= subframe;
		end
	end

	assert property (@(posedge clk_i) disable iff (reset)
		word_taken |-> cell_ce ##1 (cell_q == CNT_W'(1)))
		else $error("word taken outside cell 0");

endmodule

/* verilog/spdif_tx_top.sv */
module spdif_tx_top #(
	parameter int unsigned CLK_RATE   = 50000000,
	parameter int unsigned AUDIO_RATE = 48000
) (
	input  logic        clk_i,
	input  logic        reset,
	input  logic        half_rate,
	input  logic [15:0] audio_l,
	input  logic [15:0] audio_r,
	output logic        spdif_o,
	output logic        sample_req
);

	logic                       cell_ce;
	logic                       word_taken;
	spdif_frame_pkg::subframe_u subframe;

	// One pulse per biphase cell
	spdif_bit_timer #(
		.CLK_RATE   (CLK_RATE),
		.AUDIO_RATE (AUDIO_RATE)
	) timer_i (
		.clk_i     (clk_i),
		.reset     (reset),
		.half_rate (half_rate),
		.cell_ce   (cell_ce)
	);

	spdif_subframe_builder #(
		.AUDIO_RATE (AUDIO_RATE)
	) builder_i (
		.clk_i      (clk_i),
		.reset      (reset),
		.audio_l    (audio_l),
		.audio_r    (audio_r),
		.word_taken (word_taken),
		.subframe   (subframe),
		.sample_req (sample_req)
	);

	spdif_biphase_serializer serializer_i (
		.clk_i      (clk_i),
		.reset      (reset),
		.cell_ce    (cell_ce),
		.subframe   (subframe),
		.word_taken (word_taken),
		.spdif_o    (spdif_o)
	);

endmodule

/* verification/spdif_rx_model.sv */
module spdif_rx_model #(
	parameter int unsigned CLK_RATE   = 50000000,
	parameter int unsigned AUDIO_RATE = 48000
) (
	input  logic                       spdif_i,
	input  logic                       reset,
	input  logic                       half_rate,
	output spdif_frame_pkg::subframe_u word,
	output int unsigned                word_count,
	output int unsigned                bad_count,
	output real                        time_sum,   // Edge to edge time since reset, ns
	output int unsigned                cell_sum
);

	timeunit 1ns;
	timeprecision 100ps;

	// Average cell length, clock period times clocks per cell
	localparam real CELL_NS = (1.0e9 / CLK_RATE) * CLK_RATE
		/ (AUDIO_RATE * real'(spdif_timing_pkg::CELLS_PER_SAMPLE));

	typedef enum {SEEK, PREAMBLE, DATA} state_e;

	state_e                     state;
	spdif_frame_pkg::subframe_u acc;
	real                        last_edge;
	real                        now;
	logic                       have_edge;
	logic                       prev_level;
	logic                       half_seen;   // First half of a 1 slot seen
	int                         cells;
	int                         pre_sum;
	int                         pre_n;
	int                         pre_second;  // Second interval tells Z, X and Y apart
	int                         slot;

	initial begin
		state      = SEEK;
		have_edge  = 1'b0;
		prev_level = 1'b0;
		word_count = 0;
		bad_count  = 0;
		time_sum   = 0.0;
		cell_sum   = 0;
	end

	task automatic drop_word();
		bad_count = bad_count + 1;
		state     = SEEK;
	endtask

	task automatic start_data();
		acc       = '0;
		slot      = 4;
		half_seen = 1'b0;
		state     = DATA;
		case (pre_second)
			1:       acc.fields.pre = spdif_frame_pkg::PRE_Z;  // 3 1 1 3
			2:       acc.fields.pre = spdif_frame_pkg::PRE_Y;  // 3 2 1 2
			3:       acc.fields.pre = spdif_frame_pkg::PRE_X;  // 3 3 1 1
			default: drop_word();
		endcase
	endtask

	task automatic store_slot(input logic value);
		acc.raw[slot] = value;
		half_seen     = 1'b0;
		slot          = slot + 1;
		if (slot == 32) begin
			word       = acc;
			word_count = word_count + 1;
			state      = SEEK;
		end
	endtask

	task automatic take_interval(input int n);
		case (state)
			SEEK: begin
				// Only a preamble holds a three cell interval
				if (n == 3) begin
					state   = PREAMBLE;
					pre_sum = 3;
					pre_n   = 1;
				end
			end
			PREAMBLE: begin
				pre_n   = pre_n + 1;
				pre_sum = pre_sum + n;
				if (pre_n == 2) begin
					pre_second = n;
				end
				if (pre_sum == 8) begin
					start_data();
				end else if (pre_sum > 8) begin
					drop_word();
				end
			end
			default: begin
				if (n == 2 && !half_seen) begin
					store_slot(1'b0);
				end else if (n == 1 && half_seen) begin
					store_slot(1'b1);
				end else if (n == 1) begin
					half_seen = 1'b1;
				end else begin
					drop_word();
				end
			end
		endcase
	endtask

	always @(spdif_i or reset) begin
		if (reset) begin
			state      = SEEK;
			have_edge  = 1'b0;
			prev_level = spdif_i;
			time_sum   = 0.0;
			cell_sum   = 0;
		end else if (spdif_i !== prev_level) begin
			prev_level = spdif_i;
			now        = $realtime;
			if (have_edge) begin
				cells    = $rtoi((now - last_edge) / (half_rate ? 2.0 * CELL_NS : CELL_NS) + 0.5);
				time_sum = time_sum + (now - last_edge);
				cell_sum = cell_sum + cells;
				take_interval(cells);
			end
			have_edge = 1'b1;
			last_edge = now;
		end
	end

endmodule

/* verification/spdif_tx_tb.sv */
module spdif_tx_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int unsigned CLK_RATE     = 50000000;
	localparam int unsigned AUDIO_RATE   = 48000;
	localparam real         CLK_PERIOD   = 20.0;
	localparam int          RESET_CYCLES = 4;
	localparam int          BLOCK        = spdif_frame_pkg::BLOCK_FRAMES;
	localparam int          TABLE_LEN    = 8;
	localparam int          RUN1_FRAMES  = BLOCK + TABLE_LEN;  // Reaches the second Z
	localparam int          RUN2_FRAMES  = TABLE_LEN;          // Half rate
	localparam real         FRAME_NS     = 1.0e9 / AUDIO_RATE;
	localparam real         WATCHDOG_NS  = (3 * TABLE_LEN + BLOCK + 32) * FRAME_NS;

	localparam logic [3:0] RATE_48K = 4'b0010;

	typedef struct packed {
		logic [15:0] l;
		logic [15:0] r;
		logic [15:0] exp_l;
		logic [15:0] exp_r;
	} pair_t;

	logic        clk_i;
	logic        reset;
	logic        half_rate;
	logic [15:0] audio_l;
	logic [15:0] audio_r;
	logic        spdif_o;
	logic        sample_req;

	spdif_frame_pkg::subframe_u rx_word;
	int unsigned                rx_count;
	int unsigned                rx_bad;
	real                        rx_time;
	int unsigned                rx_cells;

	pair_t        expected_q[$];
	int           pair_idx;
	logic         pair_ready;   // Pair 0 is on the inputs during reset
	logic [31:0]  lcg_state;
	int           error_count;
	logic [191:0] status_l;
	logic [191:0] status_r;
	real          mean_full;
	real          mean_half;

	spdif_tx_top dut_i (
		.clk_i      (clk_i),
		.reset      (reset),
		.half_rate  (half_rate),
		.audio_l    (audio_l),
		.audio_r    (audio_r),
		.spdif_o    (spdif_o),
		.sample_req (sample_req)
	);

	spdif_rx_model #(
		.CLK_RATE   (CLK_RATE),
		.AUDIO_RATE (AUDIO_RATE)
	) rx_i (
		.spdif_i    (spdif_o),
		.reset      (reset),
		.half_rate  (half_rate),
		.word       (rx_word),
		.word_count (rx_count),
		.bad_count  (rx_bad),
		.time_sum   (rx_time),
		.cell_sum   (rx_cells)
	);

	// Audio words pass the link unchanged
	function automatic pair_t table_entry(input int idx);
		case (idx)
			0:       return '{16'h0000, 16'h0000, 16'h0000, 16'h0000};
			1:       return '{16'hffff, 16'h0000, 16'hffff, 16'h0000};
			2:       return '{16'h0001, 16'h8000, 16'h0001, 16'h8000};
			3:       return '{16'h8000, 16'h0001, 16'h8000, 16'h0001};
			4:       return '{16'haaaa, 16'h5555, 16'haaaa, 16'h5555};
			5:       return '{16'h1234, 16'hfedc, 16'h1234, 16'hfedc};
			6:       return '{16'h7fff, 16'h8001, 16'h7fff, 16'h8001};
			default: return '{16'h0f0f, 16'hf0f0, 16'h0f0f, 16'hf0f0};
		endcase
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Consumer status, only the sample frequency is set
	function automatic logic [191:0] status_word();
		logic [191:0] s;
		s        = '0;
		s[27:24] = RATE_48K;
		return s;
	endfunction

	task automatic compare(input logic [191:0] got, input logic [191:0] exp, input string what);
		if (got !== exp) begin
			error_count++;
			$display("mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic drive_next_pair();
		pair_t p;
		if (pair_idx < TABLE_LEN) begin
			p = table_entry(pair_idx);
		end else begin
			lcg_state = lcg_next(lcg_state);
			p.l       = lcg_state[31:16];
			lcg_state = lcg_next(lcg_state);
			p.r       = lcg_state[31:16];
			p.exp_l   = p.l;
			p.exp_r   = p.r;
		end
		audio_l <= p.l;
		audio_r <= p.r;
		expected_q.push_back(p);
		pair_idx++;
	endtask

	task automatic start_run(input logic half);
		@(posedge clk_i);
		reset     <= 1'b1;
		half_rate <= half;
		@(negedge clk_i);
		pair_idx   = 0;
		pair_ready = 1'b0;
		expected_q.delete();
		// A line that stays flat through reset gives the decoder nothing
		repeat (RESET_CYCLES - 1) begin
			@(negedge clk_i);
			compare(spdif_o, 1'b0, "spdif_o in reset");
			compare(sample_req, 1'b0, "sample_req in reset");
		end
		@(posedge clk_i);
		reset <= 1'b0;
	endtask

	task automatic check_word(input spdif_frame_pkg::subframe_u w, input int n,
			input logic collect);
		int    frame;
		logic  right;
		pair_t p;
		frame = n / 2;
		right = n[0];
		if (right) begin
			compare(w.fields.pre, spdif_frame_pkg::PRE_Y, $sformatf("preamble, right %0d", frame));
		end else if (frame % BLOCK == 0) begin
			compare(w.fields.pre, spdif_frame_pkg::PRE_Z, $sformatf("preamble, left %0d", frame));
		end else begin
			compare(w.fields.pre, spdif_frame_pkg::PRE_X, $sformatf("preamble, left %0d", frame));
		end
		compare(^w.raw[31:4], 1'b0, $sformatf("parity of subframe %0d", n));
		compare(w.fields.v, 1'b0, $sformatf("V of subframe %0d", n));
		compare(w.fields.u, 1'b0, $sformatf("U of subframe %0d", n));
		if (expected_q.size() == 0) begin
			error_count++;
			$display("subframe %0d was decoded before any audio pair was driven for it", n);
		end else if (right) begin
			p = expected_q.pop_front();
			compare(w.fields.audio, p.exp_r, $sformatf("right audio of frame %0d", frame));
		end else begin
			p = expected_q[0];
			compare(w.fields.audio, p.exp_l, $sformatf("left audio of frame %0d", frame));
		end
		if (collect && frame < BLOCK) begin
			if (right) begin
				status_r[frame] = w.fields.c;
			end else begin
				status_l[frame] = w.fields.c;
			end
		end
	endtask

	task automatic check_run(input int frames, input logic collect);
		int n;
		n = 0;
		while (n < 2 * frames) begin
			@(rx_count);
			@(negedge clk_i);  // Word and count settled
			check_word(rx_word, n, collect);
			n++;
		end
		if (collect) begin
			compare(status_l, status_word(), "left channel status block");
			compare(status_r, status_word(), "right channel status block");
		end
	endtask

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	// Next pair goes out on the edge that sees sample_req
	always @(posedge clk_i) begin
		if (reset) begin
			if (!pair_ready) begin
				drive_next_pair();
				pair_ready = 1'b1;
			end
		end else if (sample_req) begin
			drive_next_pair();
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the decoder did not deliver all subframes within %0.0f ns", WATCHDOG_NS);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		reset       = 1'b1;
		half_rate   = 1'b0;
		audio_l     = '0;
		audio_r     = '0;
		pair_idx    = 0;
		pair_ready  = 1'b0;
		lcg_state   = 32'ha683;
		error_count = 0;
		status_l    = '0;
		status_r    = '0;
		mean_full   = 0.0;
		mean_half   = 0.0;

		start_run(1'b0);
		check_run(RUN1_FRAMES, 1'b1);
		if (rx_cells > 0) begin
			mean_full = rx_time / rx_cells;
		end

		start_run(1'b1);
		check_run(RUN2_FRAMES, 1'b0);
		if (rx_cells > 0) begin
			mean_half = rx_time / rx_cells;
		end

		compare(rx_bad, 0, "intervals the decoder could not place");
		if (mean_full == 0.0 || mean_half < 1.98 * mean_full || mean_half > 2.02 * mean_full) begin
			error_count++;
			$display("half rate cell of %0.2f ns is not twice the full rate cell of %0.2f ns",
				mean_half, mean_full);
		end

		$display("errors %0d, decode errors %0d, subframes decoded %0d",
			error_count, rx_bad, rx_count);
		if (error_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* build.f */
verilog/spdif_frame_pkg.sv
verilog/spdif_timing_pkg.sv
verilog/spdif_bit_timer.sv
verilog/spdif_subframe_builder.sv
verilog/spdif_biphase_serializer.sv
verilog/spdif_tx_top.sv
verification/spdif_rx_model.sv
verification/spdif_tx_tb.sv

/* Bender.yml */
package:
  name: spdif_tx

sources:
  - files:
      - verilog/spdif_frame_pkg.sv
      - verilog/spdif_timing_pkg.sv
      - verilog/spdif_bit_timer.sv
      - verilog/spdif_subframe_builder.sv
      - verilog/spdif_biphase_serializer.sv
      - verilog/spdif_tx_top.sv
  - target: test
    files:
      - verification/spdif_rx_model.sv
      - verification/spdif_tx_tb.sv
